//--- verilog/game_defines.svh
// Game timing and sprite constants
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// 640x480 horizontal timing in pixels
`define H_ACTIVE 640
`define H_FRONT  16
`define H_SYNC   96
`define H_TOTAL  800

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_TOTAL  525

`define SPRITE_W   32
`define SPRITE_H   32
`define NUM_FRAMES 4

// Player placement and jump motion
`define PLAYER_X  64
`define GROUND_Y  400
`define APEX_Y    320
`define JUMP_STEP 16
`define ANIM_DIV  2          // Video frames per animation step

`define COLOR_KEY 16'hF81F   // Magenta marks transparent texels
`define BG_R      8'h88
`define BG_G      8'hCC
`define BG_B      8'h88

`endif

//--- verilog/game_pkg.sv
// Game graphics types
package game_pkg;

    // Scan position with active-video flag
    typedef struct packed {
        logic [9:0] hcount;
        logic [9:0] vcount;
        logic       bright;
    } scan_pos_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // One stored texel, read as a key or as colour fields
    typedef union packed {
        logic [15:0] raw;
        rgb565_t     rgb;
    } sprite_word_u;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // Host write into sprite memory
    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        logic [15:0] data;
    } sprite_wr_t;

endpackage

//--- verilog/vga_timing.sv
// VGA scan timing
`timescale 1ns/1ns
`include "game_defines.svh"

module vga_timing (
    input  logic                pix_clk,
    input  logic                rst,
    output game_pkg::scan_pos_t pos,
    output logic                hsync,
    output logic                vsync,
    output logic                frame_start
);

    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC;

    logic [9:0] hcount;
    logic [9:0] vcount;

    always_ff @(posedge pix_clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == 10'(`H_TOTAL - 1)) begin
            hcount <= '0;                           // End of line
            if (vcount == 10'(`V_TOTAL - 1))
                vcount <= '0;
            else
                vcount <= vcount + 10'd1;
        end else begin
            hcount <= hcount + 10'd1;
        end
    end

    assign pos.hcount = hcount;
    assign pos.vcount = vcount;
    assign pos.bright = (hcount < 10'(`H_ACTIVE)) && (vcount < 10'(`V_ACTIVE));

    // Both syncs are active low
    assign hsync = !((hcount >= 10'(H_SYNC_START)) && (hcount < 10'(H_SYNC_END)));
    assign vsync = !((vcount >= 10'(V_SYNC_START)) && (vcount < 10'(V_SYNC_END)));

    assign frame_start = (hcount == '0) && (vcount == '0);

    // Line counter never escapes the line length
    a_hcount_range: assert property (
        @(posedge pix_clk) disable iff (rst)
        hcount < 10'(`H_TOTAL)
    );

endmodule

//--- verilog/player_fsm.sv
// Player jump and animation control
`timescale 1ns/1ns
`include "game_defines.svh"

module player_fsm (
    input  logic       pix_clk,
    input  logic       rst,
    input  logic       frame_start,
    input  logic       jump,
    output logic [9:0] player_y,
    output logic [1:0] anim_frame
);

    localparam logic [1:0] GROUND  = 2'd0;
    localparam logic [1:0] RISING  = 2'd1;
    localparam logic [1:0] FALLING = 2'd2;

    logic [1:0] state;
    logic [7:0] div_cnt;    // Frames since last animation step

    // Jump motion, stepped once per video frame
    always_ff @(posedge pix_clk) begin
        if (rst) begin
            state    <= GROUND;
            player_y <= 10'(`GROUND_Y);
        end else if (frame_start) begin
            case (state)
                GROUND: begin
                    if (jump)
                        state <= RISING;
                end
                RISING: begin
                    if (player_y <= 10'(`APEX_Y + `JUMP_STEP)) begin
                        player_y <= 10'(`APEX_Y);     // Top of the arc
                        state    <= FALLING;
                    end else begin
                        player_y <= player_y - 10'(`JUMP_STEP);
                    end
                end
                FALLING: begin
                    if (player_y >= 10'(`GROUND_Y - `JUMP_STEP)) begin
                        player_y <= 10'(`GROUND_Y);   // Landed
                        state    <= GROUND;
                    end else begin
                        player_y <= player_y + 10'(`JUMP_STEP);
                    end
                end
                default: begin
                    state    <= GROUND;
                    player_y <= 10'(`GROUND_Y);
                end
            endcase
        end
    end

    // Animation frame divider
    always_ff @(posedge pix_clk) begin
        if (rst) begin
            div_cnt    <= '0;
            anim_frame <= '0;
        end else if (frame_start) begin
            if (div_cnt == 8'(`ANIM_DIV - 1)) begin
                div_cnt <= '0;
                if (anim_frame == 2'(`NUM_FRAMES - 1))
                    anim_frame <= '0;
                else
                    anim_frame <= anim_frame + 2'd1;
            end else begin
                div_cnt <= div_cnt + 8'd1;
            end
        end
    end

    // Player stays between apex and ground
    a_y_range: assert property (
        @(posedge pix_clk) disable iff (rst)
        (player_y >= 10'(`APEX_Y)) && (player_y <= 10'(`GROUND_Y))
    );

endmodule

//--- verilog/sprite_mem.sv
// Sprite frame memory
`timescale 1ns/1ns
`include "game_defines.svh"

module sprite_mem (
    input  logic                   pix_clk,
    input  game_pkg::sprite_wr_t   wr,
    input  logic [11:0]            rd_addr,
    output game_pkg::sprite_word_u rd_data
);

    localparam int DEPTH = `NUM_FRAMES * `SPRITE_W * `SPRITE_H;

    logic [15:0] mem [DEPTH];

    // Host write port
    always_ff @(posedge pix_clk) begin
        if (wr.en)
            mem[wr.addr] <= wr.data;
    end

    assign rd_data.raw = mem[rd_addr];     // Asynchronous read for the renderer

endmodule

//--- verilog/sprite_renderer.sv
// Player sprite renderer
`timescale 1ns/1ns
`include "game_defines.svh"

module sprite_renderer (
    input  logic                   pix_clk,
    input  logic                   rst,
    input  game_pkg::scan_pos_t    pos,
    input  logic                   hsync,
    input  logic                   vsync,
    input  logic [9:0]             player_y,
    input  logic [1:0]             anim_frame,
    output logic [11:0]            mem_addr,
    input  game_pkg::sprite_word_u mem_data,
    output game_pkg::rgb888_t      pixel,
    output logic                   pixel_opaque,
    output logic                   hsync_out,
    output logic                   vsync_out
);

    localparam int FRAME_WORDS = `SPRITE_W * `SPRITE_H;

    logic              in_x;
    logic              in_y;
    logic [9:0]        local_x;
    logic [9:0]        local_y;
    logic              is_key;
    game_pkg::rgb888_t pixel_d;
    logic              opaque_d;
    logic              bright_q;

    // Hit test against the fixed X and the current player Y
    assign in_x = (pos.hcount >= 10'(`PLAYER_X)) &&
                  (pos.hcount <  10'(`PLAYER_X + `SPRITE_W));
    assign in_y = ({1'b0, pos.vcount} >= {1'b0, player_y}) &&
                  ({1'b0, pos.vcount} <  {1'b0, player_y} + 11'(`SPRITE_H));

    assign local_x = pos.hcount - 10'(`PLAYER_X);
    assign local_y = pos.vcount - player_y;

    // Frame base plus row, column mirrored
    assign mem_addr = 12'(anim_frame) * 12'(FRAME_WORDS)
                    + 12'(local_y) * 12'(`SPRITE_W)
                    + (12'(`SPRITE_W - 1) - 12'(local_x));

    assign is_key = (mem_data.raw == `COLOR_KEY);

    always_comb begin
        if (!pos.bright) begin
            pixel_d  = '0;                             // Blanking
            opaque_d = 1'b0;
        end else if (in_x && in_y && !is_key) begin
            pixel_d.r = {mem_data.rgb.r, mem_data.rgb.r[4:2]};
            pixel_d.g = {mem_data.rgb.g, mem_data.rgb.g[5:4]};
            pixel_d.b = {mem_data.rgb.b, mem_data.rgb.b[4:2]};
            opaque_d  = 1'b1;
        end else begin
            pixel_d.r = `BG_R;                         // Background or keyed texel
            pixel_d.g = `BG_G;
            pixel_d.b = `BG_B;
            opaque_d  = 1'b0;
        end
    end

    // Output stage keeps pixel and syncs aligned
    always_ff @(posedge pix_clk) begin
        if (rst) begin
            pixel        <= '0;
            pixel_opaque <= 1'b0;
            hsync_out    <= 1'b1;
            vsync_out    <= 1'b1;
            bright_q     <= 1'b0;
        end else begin
            pixel        <= pixel_d;
            pixel_opaque <= opaque_d;
            hsync_out    <= hsync;
            vsync_out    <= vsync;
            bright_q     <= pos.bright;
        end
    end

    // Opaque output only during active video
    a_opaque_bright: assert property (
        @(posedge pix_clk) disable iff (rst)
        pixel_opaque |-> bright_q
    );

endmodule

//--- verilog/game_top.sv
// Game graphics top level
`timescale 1ns/1ns

module game_top (
    input  logic                 pix_clk,
    input  logic                 rst,
    input  logic                 jump,
    input  game_pkg::sprite_wr_t sprite_wr,
    output game_pkg::rgb888_t    pixel,
    output logic                 pixel_opaque,
    output logic                 hsync,
    output logic                 vsync,
    output logic [9:0]           player_y      // For collision logic outside
);

    game_pkg::scan_pos_t    pos;
    game_pkg::sprite_word_u mem_data;
    logic                   raw_hsync;
    logic                   raw_vsync;
    logic                   frame_start;
    logic [1:0]             anim_frame;
    logic [11:0]            mem_addr;

    vga_timing i_vga_timing (
        .pix_clk     (pix_clk),
        .rst         (rst),
        .pos         (pos),
        .hsync       (raw_hsync),
        .vsync       (raw_vsync),
        .frame_start (frame_start)
    );

    player_fsm i_player_fsm (
        .pix_clk     (pix_clk),
        .rst         (rst),
        .frame_start (frame_start),
        .jump        (jump),
        .player_y    (player_y),
        .anim_frame  (anim_frame)
    );

    sprite_mem i_sprite_mem (
        .pix_clk (pix_clk),
        .wr      (sprite_wr),
        .rd_addr (mem_addr),
        .rd_data (mem_data)
    );

    sprite_renderer i_sprite_renderer (
        .pix_clk      (pix_clk),
        .rst          (rst),
        .pos          (pos),
        .hsync        (raw_hsync),
        .vsync        (raw_vsync),
        .player_y     (player_y),
        .anim_frame   (anim_frame),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .pixel        (pixel),
        .pixel_opaque (pixel_opaque),
        .hsync_out    (hsync),
        .vsync_out    (vsync)
    );

endmodule

//--- verification/tb_game_top.sv
// Game graphics testbench
`timescale 1ns/1ns
`include "game_defines.svh"

module tb_game_top;

    localparam int MEM_WORDS    = `NUM_FRAMES * `SPRITE_W * `SPRITE_H;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int HS_START     = `H_ACTIVE + `H_FRONT;
    localparam int VS_START     = `V_ACTIVE + `V_FRONT;

    logic                 pix_clk;
    logic                 rst;
    logic                 jump;
    game_pkg::sprite_wr_t sprite_wr;
    game_pkg::rgb888_t    pixel;
    logic                 pixel_opaque;
    logic                 hsync;
    logic                 vsync;
    logic [9:0]           player_y;

    logic [15:0]       model_mem [MEM_WORDS];   // Copy of every word written
    logic [31:0]       lfsr;
    int                h_pos;
    int                v_pos;
    int                frame_cnt;               // Frame starts seen since reset
    int                m_state;                 // 0 ground, 1 rising, 2 falling
    int                m_y;
    int                m_div;
    int                m_anim;
    int                opaque_cnt;
    logic              checking;
    game_pkg::rgb888_t exp_pixel;
    logic              exp_opaque;
    logic              exp_hsync;
    logic              exp_vsync;

    game_top i_game_top (
        .pix_clk      (pix_clk),
        .rst          (rst),
        .jump         (jump),
        .sprite_wr    (sprite_wr),
        .pixel        (pixel),
        .pixel_opaque (pixel_opaque),
        .hsync        (hsync),
        .vsync        (vsync),
        .player_y     (player_y)
    );

    initial begin
        pix_clk = 1'b0;
        forever #4 pix_clk = ~pix_clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Expected pixel for a scan position, from the renderer rules
    function automatic game_pkg::rgb888_t expected_pixel(input int h, input int v, input int y,
                                                         input int anim, output logic opaque);
        game_pkg::rgb888_t px;
        logic [15:0]       word;
        int                lx;
        int                ly;
        lx     = h - `PLAYER_X;
        ly     = v - y;
        opaque = 1'b0;
        if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
            px = '0;                                 // Blanking is black
        end else begin
            px = {`BG_R, `BG_G, `BG_B};
            if (lx >= 0 && lx < `SPRITE_W && ly >= 0 && ly < `SPRITE_H) begin
                word = model_mem[12'(anim * `SPRITE_W * `SPRITE_H + ly * `SPRITE_W
                                     + (`SPRITE_W - 1 - lx))];
                if (word != `COLOR_KEY) begin
                    px     = {word[15:11], word[15:13], word[10:5], word[10:9],
                              word[4:0], word[4:2]};
                    opaque = 1'b1;
                end
            end
        end
        return px;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_pixel(input string name, input game_pkg::rgb888_t got,
                               input game_pkg::rgb888_t exp);
        if (got !== exp)
            fail_now($sformatf("Fail %s: got %h expected %h (line %0d)", name, got, exp, v_pos));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("Fail %s: got %h expected %h (line %0d)", name, got, exp, v_pos));
    endtask

    task automatic check_y(input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp)
            fail_now($sformatf("Fail player_y: got %h expected %h", got, exp));
    endtask

    // Jump and animation model, stepped on each frame start
    task automatic step_player(input logic jmp);
        case (m_state)
            0: if (jmp) m_state = 1;
            1: begin
                m_y = m_y - `JUMP_STEP;
                if (m_y <= `APEX_Y) begin
                    m_y     = `APEX_Y;
                    m_state = 2;
                end
            end
            default: begin
                m_y = m_y + `JUMP_STEP;
                if (m_y >= `GROUND_Y) begin
                    m_y     = `GROUND_Y;
                    m_state = 0;
                end
            end
        endcase
        m_div = m_div + 1;
        if (m_div == `ANIM_DIV) begin
            m_div  = 0;
            m_anim = (m_anim + 1) % `NUM_FRAMES;
        end
    endtask

    // Scan tracking, expected values for the pixel registered at this edge
    always @(posedge pix_clk) begin
        if (rst) begin
            h_pos     = 0;
            v_pos     = 0;
            frame_cnt = 0;
            m_state   = 0;
            m_y       = `GROUND_Y;
            m_div     = 0;
            m_anim    = 0;
            checking  = 1'b0;
        end else begin
            exp_pixel = expected_pixel(h_pos, v_pos, m_y, m_anim, exp_opaque);
            exp_hsync = !(h_pos >= HS_START && h_pos < HS_START + `H_SYNC);
            exp_vsync = !(v_pos >= VS_START && v_pos < VS_START + `V_SYNC);
            if (h_pos == 0 && v_pos == 0) begin
                step_player(jump);
                frame_cnt = frame_cnt + 1;
            end
            if (h_pos == `H_TOTAL - 1) begin
                h_pos = 0;
                v_pos = (v_pos == `V_TOTAL - 1) ? 0 : v_pos + 1;
            end else begin
                h_pos = h_pos + 1;
            end
            checking = 1'b1;
        end
    end

    // Compare at the falling edge where outputs are settled
    always @(negedge pix_clk) begin
        if (checking) begin
            check_pixel("pixel", pixel, exp_pixel);
            check_bit("pixel_opaque", pixel_opaque, exp_opaque);
            check_bit("hsync", hsync, exp_hsync);
            check_bit("vsync", vsync, exp_vsync);
            check_y(player_y, 10'(m_y));
            if (pixel_opaque)
                opaque_cnt = opaque_cnt + 1;
        end
    end

    task automatic wait_frames(input int n);
        int guard;
        guard = 0;
        while (frame_cnt < n) begin
            @(negedge pix_clk);
            guard++;
            if (guard > (n + 1) * FRAME_CYCLES)
                fail_now($sformatf("Timeout waiting for frame %0d", n));
        end
    endtask

    task automatic wait_vsync_low();
        int guard;
        guard = 0;
        while (vsync !== 1'b0) begin
            @(negedge pix_clk);
            guard++;
            if (guard > FRAME_CYCLES)
                fail_now("Timeout waiting for the vsync pulse");
        end
    endtask

    initial begin
        logic [15:0] word;
        logic [2:0]  pick;
        rst        = 1'b1;
        jump       = 1'b0;
        sprite_wr  = '0;
        lfsr       = 32'h46344a2e;
        opaque_cnt = 0;
        repeat (8) @(posedge pix_clk);
        rst <= 1'b0;
        @(negedge pix_clk);
        check_bit("hsync", hsync, 1'b1);          // Reset values
        check_bit("vsync", vsync, 1'b1);
        check_bit("pixel_opaque", pixel_opaque, 1'b0);
        check_y(player_y, 10'(`GROUND_Y));

        // Load finishes within the first lines, well above the sprite
        for (int a = 0; a < MEM_WORDS; a++) begin
            for (int b = 0; b < 16; b++) begin
                lfsr = lfsr_next(lfsr);
                word = {word[14:0], lfsr[0]};
            end
            for (int b = 0; b < 3; b++) begin
                lfsr = lfsr_next(lfsr);
                pick = {pick[1:0], lfsr[0]};
            end
            if (pick == 3'd0)
                word = `COLOR_KEY;                 // About one texel in eight is transparent
            @(posedge pix_clk);
            sprite_wr <= {1'b1, 12'(a), word};
            model_mem[12'(a)] = word;
        end
        @(posedge pix_clk);
        sprite_wr <= '0;

        wait_frames(4);
        wait_vsync_low();
        @(posedge pix_clk);
        jump <= 1'b1;                              // Sampled by the next frame start
        wait_frames(6);
        @(posedge pix_clk);
        jump <= 1'b0;
        wait_frames(10);
        check_y(player_y, 10'(`APEX_Y));
        wait_frames(16);
        check_y(player_y, 10'(`GROUND_Y));

        if (opaque_cnt == 0) begin
            fail_now("No opaque sprite pixel was drawn");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- sources.f
+incdir+verilog
verilog/game_pkg.sv
verilog/vga_timing.sv
verilog/player_fsm.sv
verilog/sprite_mem.sv
verilog/sprite_renderer.sv
verilog/game_top.sv
verification/tb_game_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_game_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sources.f

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
